// ==== design/vcompress_pkg.sv ====
// vcompress package
// vector sizes, element and offset types, and the pair structs
// passed between reader, offset unit and writer

package vcompress_pkg;

  // vector geometry
  localparam int VLMAX  = 8;                  // max elements per vector
  localparam int ELEN   = 32;                 // element width in bits
  localparam int OFFW   = $clog2(VLMAX + 1);  // wide enough to hold VLMAX itself
  localparam int IDXW   = $clog2(VLMAX);      // element slot index
  localparam int NPAIRS = VLMAX / 2;          // two lanes per cycle
  localparam int PAIRW  = $clog2(NPAIRS);     // pair index width

  // one vector element
  typedef logic [ELEN-1:0] elem_t;

  // destination slot or element count
  typedef logic [OFFW-1:0] offset_t;

  // vector length, same width as an offset
  typedef logic [OFFW-1:0] vl_t;

  // whole vector, slot 0 at index 0
  typedef elem_t [VLMAX-1:0] vec_t;

  // one source pair as issued by the reader
  typedef struct packed {
    logic       ena;    // pair valid this cycle
    logic       done;   // last pair of the current pass
    logic [1:0] mask2;  // lane 0 in bit 0
    elem_t      elem0;  // lower element, index 2k
    elem_t      elem1;  // upper element, index 2k+1
  } src_pair_t;

  // write request for one pair, registered by the offset unit
  typedef struct packed {
    logic [1:0] wen;       // one enable per lane
    offset_t    woffset0;  // slot for lane 0
    offset_t    woffset1;  // slot for lane 1
  } wr_pair_t;

endpackage

// ==== design/vcompress_elem_reader.sv ====
// vcompress element reader
// walks the source vector two elements per cycle, twice over,
// once per compress pass, and flags the last pair of each pass

`timescale 1ns/1ps

module vcompress_elem_reader
  import vcompress_pkg::*;
(
  input  logic             CLK,
  input  logic             nRST,
  input  logic             start,    // one-cycle pulse
  input  vl_t              vl,       // even, 2..VLMAX
  input  logic [VLMAX-1:0] mask,
  input  vec_t             src_vec,
  output logic             busy,
  output src_pair_t        rd_pair
);

  logic [PAIRW-1:0] pair_idx;   // pair k, elements 2k and 2k+1
  logic             lap;        // 0 = selected pass, 1 = unselected pass
  logic             tail;       // one drain cycle after the final pair
  logic [PAIRW:0]   last_idx;   // vl/2 - 1
  logic             last_pair;
  logic [IDXW-1:0]  lo_idx;
  logic [IDXW-1:0]  hi_idx;

  // vl is even so vl[0] is dropped
  assign last_idx  = vl[OFFW-1:1] - 1'b1;
  assign last_pair = ({1'b0, pair_idx} == last_idx);

  assign lo_idx = {pair_idx, 1'b0};
  assign hi_idx = {pair_idx, 1'b1};

  // pair issue straight from the stable source ports
  always_comb begin
    rd_pair.ena   = busy & ~tail;                  // no issue while draining
    rd_pair.done  = busy & ~tail & last_pair;
    rd_pair.mask2 = {mask[hi_idx], mask[lo_idx]};
    rd_pair.elem0 = src_vec[lo_idx];
    rd_pair.elem1 = src_vec[hi_idx];
  end

  // sequencing: idle -> lap 0 -> lap 1 -> tail -> idle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy     <= 1'b0;
      tail     <= 1'b0;
      lap      <= 1'b0;
      pair_idx <= '0;
    end else if (!busy) begin
      busy     <= start;     // start only taken while idle
      tail     <= 1'b0;
      lap      <= 1'b0;
      pair_idx <= '0;
    end else if (tail) begin
      // writer retires the final pair this cycle
      busy <= 1'b0;
      tail <= 1'b0;
    end else if (last_pair) begin
      pair_idx <= '0;        // rewind for the next lap
      lap      <= ~lap;
      if (lap) begin
        tail <= 1'b1;        // second lap done
      end
    end else begin
      pair_idx <= pair_idx + 1'b1;
    end
  end

endmodule

// ==== design/compress_offset_unit.sv ====
// compress offset unit
// turns each mask pair into two write enables and two destination
// slots; selected elements first, then unselected ones after them

`timescale 1ns/1ps

module compress_offset_unit
  import vcompress_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  src_pair_t rd_pair,
  output wr_pair_t  wr,
  output logic      pass      // low in pass 1, high in pass 2
);

  offset_t    run_off;     // next free destination slot
  logic [1:0] m_eff;       // effective mask for this pass
  offset_t    ones;        // popcount of m_eff
  offset_t    off0;
  offset_t    off1;
  logic       final_pair;  // last pair of pass 2

  // pass 2 picks up what pass 1 skipped
  assign m_eff = pass ? ~rd_pair.mask2 : rd_pair.mask2;

  assign ones = offset_t'(m_eff[0]) + offset_t'(m_eff[1]);

  // lane 1 lands after lane 0 only if lane 0 wrote
  assign off0 = run_off;
  assign off1 = run_off + offset_t'(m_eff[0]);

  assign final_pair = rd_pair.ena & rd_pair.done & pass;

  // registered write request, one cycle behind rd_pair
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr <= '0;
    end else if (rd_pair.ena) begin
      wr.wen      <= m_eff;
      wr.woffset0 <= off0;
      wr.woffset1 <= off1;
    end else begin
      wr.wen <= '0;          // offsets held, nothing enabled
    end
  end

  // running offset, carried from pass 1 into pass 2
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      run_off <= '0;
    end else if (final_pair) begin
      run_off <= '0;         // ready for the next operation
    end else if (rd_pair.ena) begin
      run_off <= run_off + ones;
    end
  end

  // pass bit flips at the end of each pass
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pass <= 1'b0;
    end else if (rd_pair.ena && rd_pair.done) begin
      pass <= ~pass;         // back to 0 after pass 2
    end
  end

endmodule

// ==== design/vcompress_writer.sv ====
// vcompress writer
// holds each element pair for one cycle so it meets its write request,
// writes enabled lanes into the destination vector, pulses done at the end

`timescale 1ns/1ps

module vcompress_writer
  import vcompress_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      start,
  input  src_pair_t rd_pair,
  input  wr_pair_t  wr,
  input  logic      pass,
  output vec_t      dst_vec,
  output logic      done
);

  elem_t elem0_q;   // lane 0 data, aligned with wr
  elem_t elem1_q;   // lane 1 data
  logic  fin_q;     // wr this cycle is the final pair
  logic  active;    // operation in flight
  logic  accept;    // start taken this cycle

  // same acceptance window as the reader busy
  assign accept = start & ~active;

  // element pair delay, data only
  always_ff @(posedge CLK) begin
    if (rd_pair.ena) begin
      elem0_q <= rd_pair.elem0;
      elem1_q <= rd_pair.elem1;
    end
  end

  // control: final-pair flag, done pulse, in-flight level
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fin_q  <= 1'b0;
      done   <= 1'b0;
      active <= 1'b0;
    end else begin
      // pass is already high for every pass-2 pair
      fin_q <= rd_pair.ena & rd_pair.done & pass;
      done  <= fin_q;        // one cycle after the last write
      if (accept) begin
        active <= 1'b1;
      end else if (fin_q) begin
        active <= 1'b0;
      end
    end
  end

  // destination array, cleared on each accepted start
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dst_vec <= '0;
    end else if (accept) begin
      dst_vec <= '0;         // slots >= vl stay zero
    end else begin
      // enabled lanes never share a slot
      if (wr.wen[0]) begin
        dst_vec[wr.woffset0[IDXW-1:0]] <= elem0_q;
      end
      if (wr.wen[1]) begin
        dst_vec[wr.woffset1[IDXW-1:0]] <= elem1_q;
      end
    end
  end

endmodule

// ==== design/vcompress_unit.sv ====
// vcompress unit
// two-lane vector compress: selected elements packed from slot 0,
// unselected ones after them, zeros from vl upward

`timescale 1ns/1ps

module vcompress_unit
  import vcompress_pkg::*;
(
  input  logic             CLK,
  input  logic             nRST,
  input  logic             start,    // one-cycle pulse
  input  vl_t              vl,       // even, held until done
  input  logic [VLMAX-1:0] mask,     // held until done
  input  vec_t             src_vec,  // held until done
  output logic             busy,
  output logic             done,     // one-cycle pulse
  output vec_t             dst_vec   // valid from done until next start
);

  src_pair_t rd_pair;   // reader -> offset unit, writer
  wr_pair_t  wr;        // offset unit -> writer
  logic      pass;      // pass 2 flag for the writer

  // source side, pair issue over two laps
  vcompress_elem_reader u_reader (
    .CLK     (CLK),
    .nRST    (nRST),
    .start   (start),
    .vl      (vl),
    .mask    (mask),
    .src_vec (src_vec),
    .busy    (busy),
    .rd_pair (rd_pair)
  );

  // enables and slots per pair
  compress_offset_unit u_offset (
    .CLK     (CLK),
    .nRST    (nRST),
    .rd_pair (rd_pair),
    .wr      (wr),
    .pass    (pass)
  );

  // destination side
  vcompress_writer u_writer (
    .CLK     (CLK),
    .nRST    (nRST),
    .start   (start),
    .rd_pair (rd_pair),
    .wr      (wr),
    .pass    (pass),
    .dst_vec (dst_vec),
    .done    (done)
  );

endmodule

// ==== bench/vcompress_tb.sv ====
// vcompress unit testbench
// runs a table of vl and mask cases on random source vectors and checks
// dst_vec against a reference model of the compress rule

`timescale 1ns/1ps

module vcompress_tb
  import vcompress_pkg::*;
;

  localparam int NCASES = 12;
  localparam int LIMIT  = NCASES * (VLMAX + 10) + 50;  // cycles before timeout

  // one table entry
  typedef struct packed {
    vl_t              vl;
    logic [VLMAX-1:0] mask;
    logic [7:0]       tag;      // mixed into the element top byte
    logic             restart;  // pulse start again mid-run
  } case_t;

  logic             CLK;
  logic             nRST;
  logic             start;
  vl_t              vl;
  logic [VLMAX-1:0] mask;
  vec_t             src_vec;
  logic             busy;
  logic             done;
  vec_t             dst_vec;

  case_t cases [NCASES];
  int    seed;
  int    err_cnt;
  int    cycle_cnt;

  vcompress_unit u_vcompress_unit (
    .CLK     (CLK),
    .nRST    (nRST),
    .start   (start),
    .vl      (vl),
    .mask    (mask),
    .src_vec (src_vec),
    .busy    (busy),
    .done    (done),
    .dst_vec (dst_vec)
  );

  // 8 ns clock
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // vl, mask, tag, restart
  function automatic void fill_table();
    cases[0]  = '{4'd8, 8'b1011_0010, 8'h01, 1'b0};  // mixed
    cases[1]  = '{4'd8, 8'b0101_0101, 8'h02, 1'b0};  // lane 0 only in every pair
    cases[2]  = '{4'd8, 8'b1010_1010, 8'h03, 1'b0};  // lane 1 only
    cases[3]  = '{4'd8, 8'b1111_1111, 8'h04, 1'b0};  // pass 1 writes all
    cases[4]  = '{4'd8, 8'b0000_0000, 8'h05, 1'b0};  // pass 2 writes all
    cases[5]  = '{4'd2, 8'b1111_1110, 8'h06, 1'b0};  // bits above vl set
    cases[6]  = '{4'd4, 8'b1111_0110, 8'h07, 1'b0};
    cases[7]  = '{4'd6, 8'b1100_1001, 8'h08, 1'b0};
    cases[8]  = '{4'd8, 8'b0110_0110, 8'h09, 1'b1};  // second start ignored
    cases[9]  = '{4'd8, 8'b1001_1001, 8'h0a, 1'b0};  // straight after restart case
    cases[10] = '{4'd6, 8'b0011_1100, 8'h0b, 1'b0};
    cases[11] = '{4'd2, 8'b0000_0001, 8'h0c, 1'b0};
  endfunction

  // selected elements in order, then unselected, then zeros
  function automatic vec_t build_expected(input vec_t src, input vl_t len,
                                          input logic [VLMAX-1:0] sel);
    vec_t res;
    int   n;
    res = '0;
    n   = 0;
    for (int i = 0; i < int'(len); i++) begin
      if (sel[i[IDXW-1:0]]) begin
        res[n[IDXW-1:0]] = src[i[IDXW-1:0]];
        n++;
      end
    end
    for (int i = 0; i < int'(len); i++) begin
      if (!sel[i[IDXW-1:0]]) begin
        res[n[IDXW-1:0]] = src[i[IDXW-1:0]];
        n++;
      end
    end
    return res;
  endfunction

  task automatic compare_slot(input int slot, input elem_t got, input elem_t exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("Fail at %0t ns: slot %0d got %h expected %h", $time, slot, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // all idle, destination empty
  task automatic check_reset();
    compare_bit("busy after reset", busy, 1'b0);
    compare_bit("done after reset", done, 1'b0);
    for (int i = 0; i < VLMAX; i++) begin
      compare_slot(i, dst_vec[i[IDXW-1:0]], '0);
    end
  endtask

  task automatic run_case(input int idx);
    case_t c;
    vec_t  src;
    vec_t  exp;
    c = cases[idx];
    for (int i = 0; i < VLMAX; i++) begin
      src[i[IDXW-1:0]] = $random(seed) ^ {c.tag, 24'h0};
    end
    exp = build_expected(src, c.vl, c.mask);

    @(posedge CLK);
    vl      <= c.vl;               // held until done
    mask    <= c.mask;
    src_vec <= src;
    start   <= 1'b1;
    @(posedge CLK);
    start   <= 1'b0;
    @(negedge CLK);
    compare_bit("busy after start", busy, 1'b1);

    if (c.restart) begin
      @(posedge CLK);
      start <= 1'b1;               // lands while busy
      @(posedge CLK);
      start <= 1'b0;
    end

    // done pulse, timeout process guards the wait
    do begin
      @(negedge CLK);
    end while (done !== 1'b1);

    for (int i = 0; i < VLMAX; i++) begin
      compare_slot(i, dst_vec[i[IDXW-1:0]], exp[i[IDXW-1:0]]);
    end

    @(negedge CLK);
    compare_bit("done one cycle later", done, 1'b0);
    compare_bit("busy after done", busy, 1'b0);   // no run started by the restart
  endtask

  // hang guard
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < LIMIT) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("timeout: done never came within %0d cycles", LIMIT);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    seed    = 63;
    err_cnt = 0;
    nRST    = 1'b0;
    start   = 1'b0;
    vl      = '0;
    mask    = '0;
    src_vec = '0;
    fill_table();

    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_reset();

    for (int k = 0; k < NCASES; k++) begin
      run_case(k);                 // back to back, no idle gap
    end

    repeat (2) @(posedge CLK);
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
design/vcompress_pkg.sv
design/vcompress_elem_reader.sv
design/compress_offset_unit.sv
design/vcompress_writer.sv
design/vcompress_unit.sv
bench/vcompress_tb.sv

// ==== Makefile ====
# Verilator build and run for the vcompress unit

TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
LINT     ?= --lint-only -Wall --timing
TOP      ?= vcompress_tb
FILELIST ?= filelist.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log search decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
